/* exec_stage.f */
hw/exec_pkg.sv
hw/shifter32.sv
hw/add_sub_unit.sv
hw/alu_core.sv
hw/funct_decode.sv
hw/exec_stage.sv
testbench/tb_clock.sv
testbench/exec_stage_asserts.sv
testbench/exec_stage_tb.sv

/* hw/add_sub_unit.sv */
`timescale 1ns/1ps

module add_sub_unit #(
    parameter int DATA_WIDTH = exec_pkg::DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic                  subtract,
    output logic [DATA_WIDTH-1:0] sum,
    output logic                  overflow,
    output logic                  lt_signed,
    output logic                  lt_unsigned
);

    logic [DATA_WIDTH-1:0] b_eff;
    logic [DATA_WIDTH:0]   full_sum;
    logic                  carry_out;

    // subtraction is a + ~b + 1 through the same carry chain
    assign b_eff = subtract ? ~b : b;

    assign full_sum = {1'b0, a} + {1'b0, b_eff} + {{DATA_WIDTH{1'b0}}, subtract};

    assign sum       = full_sum[DATA_WIDTH-1:0];
    assign carry_out = full_sum[DATA_WIDTH];

    // operands of equal sign giving a result of the other sign
    assign overflow = (a[DATA_WIDTH-1] == b_eff[DATA_WIDTH-1]) &&
                      (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);

    // both compares are only meaningful while subtracting
    assign lt_signed   = sum[DATA_WIDTH-1] ^ overflow;
    assign lt_unsigned = ~carry_out;   // no carry out of a - b means a borrow

endmodule

/* hw/alu_core.sv */
`timescale 1ns/1ps

module alu_core #(
    parameter int DATA_WIDTH  = exec_pkg::DATA_WIDTH,
    parameter int SHIFT_WIDTH = exec_pkg::SHIFT_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]  rs_val,
    input  logic [DATA_WIDTH-1:0]  rt_val,
    input  exec_pkg::alu_op_t      alu_op,
    input  logic                   shift_arith,
    input  logic                   shift_right,
    input  logic [SHIFT_WIDTH-1:0] shift_amount,
    output logic [DATA_WIDTH-1:0]  result,
    output logic                   overflow
);

    logic [DATA_WIDTH-1:0] shift_out;
    logic [DATA_WIDTH-1:0] sum;
    logic                  subtract;
    logic                  add_overflow;
    logic                  lt_signed;
    logic                  lt_unsigned;

    // the shifter takes inverted polarity on its fill control
    shifter32 #(
        .DATA_WIDTH  (DATA_WIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) shifter_inst (
        .d_in           (rt_val),
        .shift          (shift_amount),
        .arith_or_logic (~shift_arith),
        .left_or_right  (shift_right),
        .d_out          (shift_out)
    );

    assign subtract = (alu_op == exec_pkg::OP_SUB) || (alu_op == exec_pkg::OP_SLT) ||
                      (alu_op == exec_pkg::OP_SLTU);

    add_sub_unit #(
        .DATA_WIDTH (DATA_WIDTH)
    ) add_sub_inst (
        .a           (rs_val),
        .b           (rt_val),
        .subtract    (subtract),
        .sum         (sum),
        .overflow    (add_overflow),
        .lt_signed   (lt_signed),
        .lt_unsigned (lt_unsigned)
    );

    always_comb begin
        case (alu_op)
            exec_pkg::OP_SHIFT: result = shift_out;
            exec_pkg::OP_ADD,
            exec_pkg::OP_SUB:   result = sum;
            exec_pkg::OP_SLT:   result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            exec_pkg::OP_SLTU:  result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            exec_pkg::OP_OR:    result = rs_val | rt_val;
            exec_pkg::OP_XOR:   result = rs_val ^ rt_val;
            exec_pkg::OP_NOR:   result = ~(rs_val | rt_val);
            default:            result = rs_val & rt_val;
        endcase
    end

    // compares also subtract, but their overflow is not an arithmetic result
    assign overflow = add_overflow &&
                      ((alu_op == exec_pkg::OP_ADD) || (alu_op == exec_pkg::OP_SUB));

endmodule

/* hw/exec_pkg.sv */
package exec_pkg;

    localparam int DATA_WIDTH  = 32;
    localparam int SHIFT_WIDTH = 5;   // log2 of DATA_WIDTH

    // operation selected inside the ALU
    typedef enum logic [3:0] {
        OP_SHIFT = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_SLT   = 4'd3,
        OP_SLTU  = 4'd4,
        OP_AND   = 4'd5,
        OP_OR    = 4'd6,
        OP_XOR   = 4'd7,
        OP_NOR   = 4'd8
    } alu_op_t;

    // R-type funct field values
    localparam logic [5:0] FUNCT_SLL  = 6'h00;
    localparam logic [5:0] FUNCT_SRL  = 6'h02;
    localparam logic [5:0] FUNCT_SRA  = 6'h03;
    localparam logic [5:0] FUNCT_SLLV = 6'h04;
    localparam logic [5:0] FUNCT_SRLV = 6'h06;
    localparam logic [5:0] FUNCT_SRAV = 6'h07;
    localparam logic [5:0] FUNCT_ADD  = 6'h20;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_SUB  = 6'h22;
    localparam logic [5:0] FUNCT_SUBU = 6'h23;
    localparam logic [5:0] FUNCT_AND  = 6'h24;
    localparam logic [5:0] FUNCT_OR   = 6'h25;
    localparam logic [5:0] FUNCT_XOR  = 6'h26;
    localparam logic [5:0] FUNCT_NOR  = 6'h27;
    localparam logic [5:0] FUNCT_SLT  = 6'h2a;
    localparam logic [5:0] FUNCT_SLTU = 6'h2b;

endpackage

/* hw/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage #(
    parameter int DATA_WIDTH  = exec_pkg::DATA_WIDTH,
    parameter int SHIFT_WIDTH = exec_pkg::SHIFT_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [5:0]             funct,
    input  logic [SHIFT_WIDTH-1:0] shamt,
    input  logic [DATA_WIDTH-1:0]  rs_val,
    input  logic [DATA_WIDTH-1:0]  rt_val,
    output logic                   out_valid,
    output logic [DATA_WIDTH-1:0]  result,
    output logic                   overflow,
    output logic                   illegal
);

    exec_pkg::alu_op_t      alu_op;
    logic                   shift_arith;
    logic                   shift_right;
    logic                   use_var_shift;
    logic                   check_overflow;
    logic                   dec_illegal;
    logic [SHIFT_WIDTH-1:0] shift_amount;
    logic [DATA_WIDTH-1:0]  alu_result;
    logic                   alu_overflow;
    logic [DATA_WIDTH-1:0]  next_result;
    logic                   next_overflow;

    funct_decode decode_inst (
        .funct          (funct),
        .alu_op         (alu_op),
        .shift_arith    (shift_arith),
        .shift_right    (shift_right),
        .use_var_shift  (use_var_shift),
        .check_overflow (check_overflow),
        .illegal        (dec_illegal)
    );

    // variable shifts take their amount from the low bits of rs
    assign shift_amount = use_var_shift ? rs_val[SHIFT_WIDTH-1:0] : shamt;

    alu_core #(
        .DATA_WIDTH  (DATA_WIDTH),
        .SHIFT_WIDTH (SHIFT_WIDTH)
    ) alu_inst (
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .alu_op       (alu_op),
        .shift_arith  (shift_arith),
        .shift_right  (shift_right),
        .shift_amount (shift_amount),
        .result       (alu_result),
        .overflow     (alu_overflow)
    );

    assign next_result   = dec_illegal ? '0 : alu_result;
    assign next_overflow = check_overflow & alu_overflow;   // ADDU and SUBU never trap

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
            overflow  <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                result   <= next_result;
                overflow <= next_overflow;
                illegal  <= dec_illegal;
            end
        end
    end

endmodule

/* hw/funct_decode.sv */
`timescale 1ns/1ps

module funct_decode (
    input  logic [5:0]        funct,
    output exec_pkg::alu_op_t alu_op,
    output logic              shift_arith,
    output logic              shift_right,
    output logic              use_var_shift,
    output logic              check_overflow,
    output logic              illegal
);

    always_comb begin
        alu_op         = exec_pkg::OP_AND;
        shift_arith    = 1'b0;
        shift_right    = 1'b0;
        use_var_shift  = 1'b0;
        check_overflow = 1'b0;
        illegal        = 1'b0;
        case (funct)
            exec_pkg::FUNCT_SLL: alu_op = exec_pkg::OP_SHIFT;
            exec_pkg::FUNCT_SRL: begin
                alu_op      = exec_pkg::OP_SHIFT;
                shift_right = 1'b1;
            end
            exec_pkg::FUNCT_SRA: begin
                alu_op      = exec_pkg::OP_SHIFT;
                shift_right = 1'b1;
                shift_arith = 1'b1;
            end
            exec_pkg::FUNCT_SLLV: begin
                alu_op        = exec_pkg::OP_SHIFT;
                use_var_shift = 1'b1;   // amount from rs
            end
            exec_pkg::FUNCT_SRLV: begin
                alu_op        = exec_pkg::OP_SHIFT;
                shift_right   = 1'b1;
                use_var_shift = 1'b1;
            end
            exec_pkg::FUNCT_SRAV: begin
                alu_op        = exec_pkg::OP_SHIFT;
                shift_right   = 1'b1;
                shift_arith   = 1'b1;
                use_var_shift = 1'b1;
            end
            exec_pkg::FUNCT_ADD: begin
                alu_op         = exec_pkg::OP_ADD;
                check_overflow = 1'b1;
            end
            exec_pkg::FUNCT_ADDU: alu_op = exec_pkg::OP_ADD;
            exec_pkg::FUNCT_SUB: begin
                alu_op         = exec_pkg::OP_SUB;
                check_overflow = 1'b1;
            end
            exec_pkg::FUNCT_SUBU: alu_op = exec_pkg::OP_SUB;
            exec_pkg::FUNCT_AND:  alu_op = exec_pkg::OP_AND;
            exec_pkg::FUNCT_OR:   alu_op = exec_pkg::OP_OR;
            exec_pkg::FUNCT_XOR:  alu_op = exec_pkg::OP_XOR;
            exec_pkg::FUNCT_NOR:  alu_op = exec_pkg::OP_NOR;
            exec_pkg::FUNCT_SLT:  alu_op = exec_pkg::OP_SLT;
            exec_pkg::FUNCT_SLTU: alu_op = exec_pkg::OP_SLTU;
            default:              illegal = 1'b1;
        endcase
    end

endmodule

/* hw/shifter32.sv */
`timescale 1ns/1ps

module shifter32 #(
    parameter int DATA_WIDTH  = exec_pkg::DATA_WIDTH,
    parameter int SHIFT_WIDTH = exec_pkg::SHIFT_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]  d_in,
    input  logic [SHIFT_WIDTH-1:0] shift,
    input  logic                   arith_or_logic,  // high selects logical, zero fill
    input  logic                   left_or_right,   // high selects a right shift
    output logic [DATA_WIDTH-1:0]  d_out
);

    logic                  msb_fill;
    logic [DATA_WIDTH-1:0] shifter_d_in;
    logic [DATA_WIDTH-1:0] shifter_d_out;

    // col[0] is the array input, col[SHIFT_WIDTH] its output
    logic [SHIFT_WIDTH:0][DATA_WIDTH-1:0] col;

    assign msb_fill = arith_or_logic ? 1'b0 : d_in[DATA_WIDTH-1];

    // the array only shifts right, so a left shift mirrors the word on the way in
    genvar i;
    generate
        for (i = 0; i < DATA_WIDTH; i++) begin : g_rev_in
            assign shifter_d_in[i] = left_or_right ? d_in[i] : d_in[DATA_WIDTH-1-i];
        end
    endgenerate

    assign col[0] = shifter_d_in;

    // column k moves the word by 2**k when shift[k] is set
    genvar k;
    genvar b;
    generate
        for (k = 0; k < SHIFT_WIDTH; k++) begin : g_col
            localparam int STEP = 2 ** k;
            for (b = 0; b < DATA_WIDTH; b++) begin : g_bit
                if (b + STEP < DATA_WIDTH) begin : g_pass
                    assign col[k+1][b] = shift[k] ? col[k][b+STEP] : col[k][b];
                end else begin : g_fill
                    assign col[k+1][b] = shift[k] ? msb_fill : col[k][b];
                end
            end
        end
    endgenerate

    assign shifter_d_out = col[SHIFT_WIDTH];

    // mirror back for left shifts
    generate
        for (i = 0; i < DATA_WIDTH; i++) begin : g_rev_out
            assign d_out[i] = left_or_right ? shifter_d_out[i]
                                            : shifter_d_out[DATA_WIDTH-1-i];
        end
    endgenerate

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the exec_stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_stage.f \
    --top-module exec_stage_tb -o exec_stage_sim

out=$(./obj_dir/exec_stage_sim)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

/* testbench/exec_stage_asserts.sv */
`timescale 1ns/1ps

module exec_stage_asserts (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic [5:0]  funct,
    input logic [4:0]  shamt,
    input logic [31:0] rs_val,
    input logic [31:0] rt_val,
    input logic        out_valid,
    input logic [31:0] result,
    input logic        overflow,
    input logic        illegal
);

    logic        prev_valid;
    logic [5:0]  prev_funct;
    logic [4:0]  prev_amt;
    logic [31:0] prev_rs;
    logic [31:0] prev_rt;
    logic [31:0] exp_result;
    logic        exp_overflow;
    logic        exp_illegal;

    always_ff @(posedge clk) begin
        prev_valid <= in_valid && !rst;
        prev_funct <= funct;
        prev_amt   <= funct[2] ? rs_val[4:0] : shamt;   // variable shifts use rs
        prev_rs    <= rs_val;
        prev_rt    <= rt_val;
    end

    always_comb begin
        exp_result   = '0;
        exp_overflow = 1'b0;
        exp_illegal  = 1'b0;
        case (prev_funct)
            6'h00, 6'h04: exp_result = prev_rt << prev_amt;
            6'h02, 6'h06: exp_result = prev_rt >> prev_amt;
            6'h03, 6'h07: exp_result = $signed(prev_rt) >>> prev_amt;
            6'h20, 6'h21: begin
                exp_result   = prev_rs + prev_rt;
                exp_overflow = (prev_funct == 6'h20) && (prev_rs[31] == prev_rt[31])
                               && (exp_result[31] != prev_rs[31]);
            end
            6'h22, 6'h23: begin
                exp_result   = prev_rs - prev_rt;
                exp_overflow = (prev_funct == 6'h22) && (prev_rs[31] != prev_rt[31])
                               && (exp_result[31] != prev_rs[31]);
            end
            6'h24: exp_result = prev_rs & prev_rt;
            6'h25: exp_result = prev_rs | prev_rt;
            6'h26: exp_result = prev_rs ^ prev_rt;
            6'h27: exp_result = ~(prev_rs | prev_rt);
            6'h2a: exp_result = {31'b0, $signed(prev_rs) < $signed(prev_rt)};
            6'h2b: exp_result = {31'b0, prev_rs < prev_rt};
            default: exp_illegal = 1'b1;
        endcase
    end

    valid_timing: assert property (@(posedge clk) disable iff (rst) out_valid == prev_valid)
        else $error("out_valid does not follow in_valid by one cycle");

    result_value: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> result == exp_result)
        else $error("MISMATCH result for funct %h: expected %h actual %h", prev_funct,
                    exp_result, result);

    overflow_rule: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> overflow == exp_overflow)
        else $error("MISMATCH overflow for funct %h: expected %b actual %b", prev_funct,
                    exp_overflow, overflow);

    illegal_rule: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (illegal == exp_illegal) && !(illegal && (overflow || result != 0)))
        else $error("MISMATCH illegal for funct %h: expected %b actual %b", prev_funct,
                    exp_illegal, illegal);

endmodule

bind exec_stage exec_stage_asserts asserts_inst (.*);

/* testbench/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb;

    localparam int MAX_CYCLES = 2000;   // generous bound over the few hundred stimulus cycles

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic        out_valid;
    logic [31:0] result;
    logic        overflow;
    logic        illegal;

    integer      seed = 72302;
    int          cycles = 0;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name = "reset";
    logic        exp_valid = 1'b0;
    logic [33:0] exp_word = '0;   // {illegal, overflow, result}
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    logic [31:0] rnd_c;
    logic [5:0]  shift_ops [6];
    int          amounts [4];

    tb_clock #(.PERIOD(40ns)) clock_inst (.clk(clk));

    exec_stage exec_stage_inst (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [33:0] predict(logic [5:0] f, logic [4:0] sa,
                                            logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        logic [4:0]  amt;
        logic        ovf;
        logic        ill;
        r   = '0;
        ovf = 1'b0;
        ill = 1'b0;
        amt = f[2] ? a[4:0] : sa;
        case (f)
            exec_pkg::FUNCT_SLL, exec_pkg::FUNCT_SLLV: r = b << amt;
            exec_pkg::FUNCT_SRL, exec_pkg::FUNCT_SRLV: r = b >> amt;
            exec_pkg::FUNCT_SRA, exec_pkg::FUNCT_SRAV: r = $signed(b) >>> amt;
            exec_pkg::FUNCT_ADD, exec_pkg::FUNCT_ADDU: begin
                r   = a + b;
                ovf = (f == exec_pkg::FUNCT_ADD) && (a[31] == b[31]) && (r[31] != a[31]);
            end
            exec_pkg::FUNCT_SUB, exec_pkg::FUNCT_SUBU: begin
                r   = a - b;
                ovf = (f == exec_pkg::FUNCT_SUB) && (a[31] != b[31]) && (r[31] != a[31]);
            end
            exec_pkg::FUNCT_AND:  r = a & b;
            exec_pkg::FUNCT_OR:   r = a | b;
            exec_pkg::FUNCT_XOR:  r = a ^ b;
            exec_pkg::FUNCT_NOR:  r = ~(a | b);
            exec_pkg::FUNCT_SLT:  r = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::FUNCT_SLTU: r = {31'b0, a < b};
            default:              ill = 1'b1;
        endcase
        return {ill, ovf, r};
    endfunction

    task automatic check_outputs();
        if (out_valid !== exp_valid) begin
            $display("MISMATCH %s: out_valid expected %b actual %b", test_name,
                     exp_valid, out_valid);
            test_errors++;
        end else if (exp_valid && ({illegal, overflow, result} !== exp_word)) begin
            $display("MISMATCH %s: expected %h actual %h", test_name, exp_word,
                     {illegal, overflow, result});
            test_errors++;
        end
    endtask

    // each falling edge checks the previous op's output and then drives the next op
    task automatic step(input logic v, input logic [5:0] f, input logic [4:0] sa,
                        input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        check_outputs();
        in_valid  = v;
        funct     = f;
        shamt     = sa;
        rs_val    = a;
        rt_val    = b;
        exp_valid = v;
        exp_word  = predict(f, sa, a, b);
    endtask

    task automatic finish_test(input string next_name);
        step(1'b0, 6'h00, 5'd0, '0, '0);   // drain the last op
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %s: %0s (%0d errors)", test_name, test_errors ? "fail" : "ok",
                 test_errors);
        total_errors += test_errors;
        test_errors = 0;
        test_name   = next_name;
    endtask

    initial begin
        shift_ops = '{exec_pkg::FUNCT_SLL, exec_pkg::FUNCT_SRL, exec_pkg::FUNCT_SRA,
                      exec_pkg::FUNCT_SLLV, exec_pkg::FUNCT_SRLV, exec_pkg::FUNCT_SRAV};
        amounts   = '{0, 1, 16, 31};
        rst       = 1'b1;
        in_valid  = 1'b0;
        funct     = '0;
        shamt     = '0;
        rs_val    = '0;
        rt_val    = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        finish_test("shift_corners");
        foreach (shift_ops[i]) begin
            foreach (amounts[j]) begin
                rnd_a = $random(seed);
                // the amount source left unused holds the complement of the other one
                step(1'b1, shift_ops[i], amounts[j][4:0], {rnd_a[31:5], ~amounts[j][4:0]},
                     32'h8765_4321);
                step(1'b1, shift_ops[i], ~amounts[j][4:0], {rnd_a[31:5], amounts[j][4:0]},
                     32'h1234_5678);
            end
        end
        finish_test("shift_random");
        repeat (40) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd_c = $random(seed);
            step(1'b1, shift_ops[rnd_c[7:0] % 6], rnd_c[12:8], rnd_a, rnd_b);
        end
        finish_test("arith");
        step(1'b1, exec_pkg::FUNCT_ADD, 5'd0, 32'h7fff_ffff, 32'h1);
        step(1'b1, exec_pkg::FUNCT_ADDU, 5'd0, 32'h7fff_ffff, 32'h1);
        step(1'b1, exec_pkg::FUNCT_ADD, 5'd0, 32'h8000_0000, 32'h8000_0000);
        step(1'b1, exec_pkg::FUNCT_ADD, 5'd0, 32'hffff_ffff, 32'h1);
        step(1'b1, exec_pkg::FUNCT_SUB, 5'd0, 32'h8000_0000, 32'h1);
        step(1'b1, exec_pkg::FUNCT_SUBU, 5'd0, 32'h8000_0000, 32'h1);
        step(1'b1, exec_pkg::FUNCT_SUB, 5'd0, 32'h7fff_ffff, 32'hffff_ffff);
        step(1'b1, exec_pkg::FUNCT_SUB, 5'd0, 32'h5, 32'h7);
        finish_test("compare");
        step(1'b1, exec_pkg::FUNCT_SLT, 5'd0, 32'hffff_ffff, 32'h1);
        step(1'b1, exec_pkg::FUNCT_SLTU, 5'd0, 32'hffff_ffff, 32'h1);
        step(1'b1, exec_pkg::FUNCT_SLT, 5'd0, 32'h1, 32'h8000_0000);
        step(1'b1, exec_pkg::FUNCT_SLTU, 5'd0, 32'h1, 32'h8000_0000);
        step(1'b1, exec_pkg::FUNCT_SLT, 5'd0, 32'h8000_0000, 32'h7fff_ffff);
        step(1'b1, exec_pkg::FUNCT_SLT, 5'd0, 32'h3, 32'h3);
        step(1'b1, exec_pkg::FUNCT_SLTU, 5'd0, 32'h2, 32'h3);
        finish_test("logic");
        repeat (5) begin
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            step(1'b1, exec_pkg::FUNCT_AND, 5'd0, rnd_a, rnd_b);
            step(1'b0, exec_pkg::FUNCT_OR, 5'd0, rnd_a, rnd_b);   // idle gap
            step(1'b1, exec_pkg::FUNCT_OR, 5'd0, rnd_a, rnd_b);
            step(1'b1, exec_pkg::FUNCT_XOR, 5'd0, rnd_a, rnd_b);
            step(1'b1, exec_pkg::FUNCT_NOR, 5'd0, rnd_a, rnd_b);
        end
        finish_test("illegal");
        step(1'b1, 6'h01, 5'd3, 32'h7fff_ffff, 32'h1);
        step(1'b1, 6'h3f, 5'd0, 32'hdead_beef, 32'h1);
        step(1'b1, 6'h10, 5'd0, 32'h1, 32'h1);
        finish_test("done");
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 40ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule
